/* vlog.f */
+incdir+source
source/cam_cfg_pkg.sv
source/cfg_rom.sv
source/cfg_sequencer.sv
source/sccb_master.sv
source/cam_cfg_top.sv
test/tb_sccb_monitor.sv
test/tb_cam_cfg.sv

/* test/tb_cam_cfg.sv */
`timescale 1ns/100ps
`include "cam_cfg_config.svh"

module tb_cam_cfg;

    localparam int     CLK_PERIOD  = 20;
    localparam int     NUM_WR      = 31;       // Register writes per run
    localparam int     DELAY_AFTER = 0;        // Delay marker follows this write
    localparam longint RUN_CYCLES  = NUM_WR * 58 * `CAM_SCCB_HALF + `CAM_DELAY_CYCLES;
    localparam longint WDOG_CYCLES = 2 * RUN_CYCLES + 40000;

    logic clk;
    logic rstn;
    logic start;
    logic busy;
    logic done;
    logic sioc;
    logic siod;
    logic siod_oe;
    int   seed = 47561;

    // Writes in ROM order, address in the upper byte
    logic [15:0] exp_wr [0:NUM_WR-1] = '{
        16'h1280, 16'h1101, 16'h1206, 16'h3a04, 16'h8c02, 16'h40d0, 16'h0c00, 16'h3e00,
        16'h703a, 16'h7135, 16'h7211, 16'h73f0, 16'ha202, 16'h1713, 16'h1801, 16'h32b6,
        16'h1902, 16'h1a7a, 16'h030a, 16'h4f80, 16'h5080, 16'h5100, 16'h5222, 16'h535e,
        16'h5480, 16'h589e, 16'h0e61, 16'h13e7, 16'h1e31, 16'h3dc3, 16'h1500
    };

    cam_cfg_top dut (
        .i_clk     (clk),
        .i_rstn    (rstn),
        .i_start   (start),
        .o_busy    (busy),
        .o_done    (done),
        .o_sioc    (sioc),
        .o_siod    (siod),
        .o_siod_oe (siod_oe)
    );

    tb_sccb_monitor mon (
        .i_clk     (clk),
        .i_rstn    (rstn),
        .i_sioc    (sioc),
        .i_siod    (siod),
        .i_siod_oe (siod_oe)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s got 0x%0h exp 0x%0h", name, act, exp));
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;                              // Seen on this edge
    endtask

    task automatic wait_for_done();
        longint n;
        n = 0;
        @(negedge clk);
        while (!done) begin
            n++;
            if (n > RUN_CYCLES + 20000) begin
                abort_run("o_done did not rise within one configuration run");
            end
            @(negedge clk);
        end
    endtask

    // One run's records against the table, starting at record base
    task automatic check_records(input int base);
        int r;
        check_equal("record_count", mon.rec_count - base, NUM_WR);
        for (int i = 0; i < NUM_WR; i++) begin
            r = base + i;
            if (mon.rec_addr[r] == 8'hFF) begin
                abort_run($sformatf("record %0d sent a marker word on the bus", r));
            end
            check_equal($sformatf("rec%0d_id", r), mon.rec_id[r], `CAM_SCCB_ID);
            check_equal($sformatf("rec%0d_addr", r), mon.rec_addr[r], exp_wr[i][15:8]);
            check_equal($sformatf("rec%0d_data", r), mon.rec_data[r], exp_wr[i][7:0]);
            check_equal($sformatf("rec%0d_bits", r), mon.rec_bits[r], 27);
        end
    endtask

    task automatic test_reset_idle();
        repeat (200) begin
            @(negedge clk);
            check_equal("o_busy", busy, 1'b0);
            check_equal("o_done", done, 1'b0);
            check_equal("o_sioc", sioc, 1'b1);
            check_equal("o_siod", siod, 1'b1);
            check_equal("o_siod_oe", siod_oe, 1'b1);
        end
        check_equal("idle_record_count", mon.rec_count, 0);
    endtask

    task automatic test_full_sequence();
        pulse_start();
        @(negedge clk);
        check_equal("o_busy", busy, 1'b1);          // Rises right after start
        wait_for_done();
        check_records(0);
    endtask

    task automatic test_delay_gap();
        longint gap;
        for (int i = 0; i < NUM_WR - 1; i++) begin
            gap = mon.rec_start[i + 1] - mon.rec_stop[i];
            if (i == DELAY_AFTER && gap < `CAM_DELAY_CYCLES) begin
                abort_run($sformatf("gap after write %0d is %0d clocks, shorter than the delay",
                                    i, gap));
            end
            if (i != DELAY_AFTER && gap >= `CAM_DELAY_CYCLES) begin
                abort_run($sformatf("gap after write %0d is %0d clocks, too long", i, gap));
            end
        end
    endtask

    task automatic test_done_level();
        int count_before;
        check_equal("o_busy_at_done", busy, 1'b0);
        count_before = mon.rec_count;
        repeat (500) begin
            @(negedge clk);
            check_equal("o_done_hold", done, 1'b1);
        end
        check_equal("record_count_after_done", mon.rec_count, count_before);
    endtask

    task automatic test_start_while_busy();
        int base;
        int mid;
        base = mon.rec_count;
        mid  = 1000 + ($unsigned($random(seed)) % 200000);  // Somewhere inside the run
        pulse_start();
        @(negedge clk);
        check_equal("o_done_after_start", done, 1'b0);
        check_equal("o_busy_after_start", busy, 1'b1);
        repeat (mid) @(negedge clk);
        check_equal("o_busy_mid_run", busy, 1'b1);
        pulse_start();                               // Must be ignored
        @(negedge clk);
        check_equal("o_busy_second_start", busy, 1'b1);
        wait_for_done();
        check_records(base);
    endtask

    // Watchdog sized for two runs plus idle tests
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        abort_run("simulation timed out before the tests finished");
    end

    initial begin
        start = 1'b0;
        rstn  = 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        test_reset_idle();
        test_full_sequence();
        test_delay_gap();
        test_done_level();
        test_start_while_busy();
        $display("** PASS **");
        $finish;
    end

endmodule

/* test/tb_sccb_monitor.sv */
`timescale 1ns/100ps

module tb_sccb_monitor (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_sioc,
    input  logic i_siod,
    input  logic i_siod_oe     // Low means line floats high
);

    localparam int MAX_REC = 80;            // Room for two full runs

    // Captured write records, read by the testbench
    logic [7:0]  rec_id    [0:MAX_REC-1];
    logic [7:0]  rec_addr  [0:MAX_REC-1];
    logic [7:0]  rec_data  [0:MAX_REC-1];
    int          rec_bits  [0:MAX_REC-1];   // SIOC pulses between start and stop
    longint      rec_start [0:MAX_REC-1];   // Clock count at start condition
    longint      rec_stop  [0:MAX_REC-1];   // Clock count at stop condition
    int          rec_count;

    logic        sda;                       // Bus level with pull-up
    logic        sioc_q;
    logic        sda_q;
    logic        in_cycle;                  // Between start and stop
    logic        bit_pending;               // SIOC rose, bit not yet closed
    logic        pending_val;
    logic [31:0] shift;                     // All bits, don't-care ones too
    int          bit_cnt;
    longint      clk_cnt;
    longint      start_cnt;

    assign sda = i_siod_oe ? i_siod : 1'b1;

    always @(posedge i_clk) begin
        if (!i_rstn) begin
            rec_count   <= 0;
            sioc_q      <= 1'b1;
            sda_q       <= 1'b1;
            in_cycle    <= 1'b0;
            bit_pending <= 1'b0;
            pending_val <= 1'b0;
            shift       <= '0;
            bit_cnt     <= 0;
            clk_cnt     <= 0;
            start_cnt   <= 0;
        end else begin
            clk_cnt <= clk_cnt + 1;
            sioc_q  <= i_sioc;
            sda_q   <= sda;
            if (i_sioc && sioc_q && sda_q && !sda) begin            // Start condition
                in_cycle    <= 1'b1;
                bit_pending <= 1'b0;
                bit_cnt     <= 0;
                shift       <= '0;
                start_cnt   <= clk_cnt;
            end else if (in_cycle && i_sioc && sioc_q && !sda_q && sda) begin  // Stop
                in_cycle <= 1'b0;
                if (rec_count < MAX_REC) begin
                    rec_id[rec_count]    <= shift[26:19];            // Skip ninth bits
                    rec_addr[rec_count]  <= shift[17:10];
                    rec_data[rec_count]  <= shift[8:1];
                    rec_bits[rec_count]  <= bit_cnt;
                    rec_start[rec_count] <= start_cnt;
                    rec_stop[rec_count]  <= clk_cnt;
                end
                rec_count <= rec_count + 1;
            end else if (in_cycle) begin
                if (i_sioc && !sioc_q) begin                         // Rise, take level
                    bit_pending <= 1'b1;
                    pending_val <= sda;
                end else if (!i_sioc && sioc_q && bit_pending) begin // Fall closes bit
                    bit_pending <= 1'b0;
                    shift       <= {shift[30:0], pending_val};
                    bit_cnt     <= bit_cnt + 1;
                end
            end
        end
    end

endmodule

/* source/cam_cfg_top.sv */
`timescale 1ns/100ps
`include "cam_cfg_config.svh"

module cam_cfg_top (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_start,      // Begin configuration run
    output logic o_busy,
    output logic o_done,       // Run finished, held
    output logic o_sioc,
    output logic o_siod,
    output logic o_siod_oe     // Board pulls SIOD up when low
);

    logic [`CAM_ROM_AW-1:0] rom_addr;
    cam_cfg_pkg::cfg_word_u rom_word;
    cam_cfg_pkg::sccb_req_t sccb_req;
    logic                   sccb_stb;
    logic                   sccb_busy;  // Only back-pressure path

    cfg_rom u_rom (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_addr (rom_addr),
        .o_data (rom_word)
    );

    cfg_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_start     (i_start),
        .i_word      (rom_word),
        .i_sccb_busy (sccb_busy),
        .o_addr      (rom_addr),
        .o_req       (sccb_req),
        .o_req_stb   (sccb_stb),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    sccb_master u_sccb (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_req     (sccb_req),
        .i_req_stb (sccb_stb),
        .o_busy    (sccb_busy),
        .o_sioc    (o_sioc),
        .o_siod    (o_siod),
        .o_siod_oe (o_siod_oe)
    );

endmodule

/* source/sccb_master.sv */
`timescale 1ns/100ps
`include "cam_cfg_config.svh"

module sccb_master (
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  cam_cfg_pkg::sccb_req_t i_req,
    input  logic                   i_req_stb,   // Taken only while idle
    output logic                   o_busy,
    output logic                   o_sioc,
    output logic                   o_siod,
    output logic                   o_siod_oe    // Low releases SIOD
);

    localparam int              HALF_W   = $clog2(`CAM_SCCB_HALF);
    localparam logic [HALF_W-1:0] TICK_END = HALF_W'(`CAM_SCCB_HALF - 1);
    localparam logic [HALF_W-1:0] TICK_MID = HALF_W'(`CAM_SCCB_HALF / 2 - 1);
    localparam int              FRAME_W  = 27;          // Three phases of nine bits

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,       // SIOD low under high SIOC
        ST_BIT_LO,      // SIOC low, data changes mid half
        ST_BIT_HI,      // SIOC high, data stable
        ST_STOP_LO,     // Pull SIOD low ahead of stop
        ST_STOP_HI,     // SIOC high with SIOD low
        ST_STOP_END     // SIOD back high, bus free
    } state_t;

    state_t             state;
    logic [HALF_W-1:0]  tick;       // Clocks within a half period
    logic [3:0]         bit_cnt;    // 0..8, 8 is the don't-care bit
    logic [1:0]         phase;      // ID, address, data
    logic [FRAME_W-1:0] frame;      // Shifts out MSB first
    logic               tick_end;
    logic               tick_mid;
    logic               last_bit;

    assign tick_end = (tick == TICK_END);
    assign tick_mid = (tick == TICK_MID);
    assign last_bit = (bit_cnt == 4'd8) && (phase == 2'd2);

    assign o_busy = (state != ST_IDLE);    // Set on the strobe edge

    // Serial frame, ninth bits left high as released line level
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_req_stb) begin
            frame <= {`CAM_SCCB_ID, 1'b1, i_req.reg_addr, 1'b1, i_req.reg_data, 1'b1};
        end else if (state == ST_BIT_HI && tick_end) begin
            frame <= {frame[FRAME_W-2:0], 1'b1};
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state     <= ST_IDLE;
            tick      <= '0;
            bit_cnt   <= '0;
            phase     <= '0;
            o_sioc    <= 1'b1;
            o_siod    <= 1'b1;
            o_siod_oe <= 1'b1;
        end else begin
            if (state == ST_IDLE || tick_end) begin
                tick <= '0;
            end else begin
                tick <= tick + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (i_req_stb) begin
                        o_siod  <= 1'b0;           // Start condition
                        bit_cnt <= '0;
                        phase   <= '0;
                        state   <= ST_START;
                    end
                end
                ST_START: begin
                    if (tick_end) begin
                        o_sioc <= 1'b0;
                        state  <= ST_BIT_LO;
                    end
                end
                ST_BIT_LO: begin
                    if (tick_mid) begin
                        o_siod    <= frame[FRAME_W-1];
                        o_siod_oe <= (bit_cnt != 4'd8); // Release on ninth bit
                    end
                    if (tick_end) begin
                        o_sioc <= 1'b1;
                        state  <= ST_BIT_HI;
                    end
                end
                ST_BIT_HI: begin
                    if (tick_end) begin
                        o_sioc <= 1'b0;
                        if (last_bit) begin
                            state <= ST_STOP_LO;
                        end else begin
                            state <= ST_BIT_LO;
                            if (bit_cnt == 4'd8) begin
                                bit_cnt <= '0;
                                phase   <= phase + 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                ST_STOP_LO: begin
                    if (tick_mid) begin
                        o_siod    <= 1'b0;         // Drive again for the stop edge
                        o_siod_oe <= 1'b1;
                    end
                    if (tick_end) begin
                        o_sioc <= 1'b1;
                        state  <= ST_STOP_HI;
                    end
                end
                ST_STOP_HI: begin
                    if (tick_end) begin
                        o_siod <= 1'b1;            // Stop condition
                        state  <= ST_STOP_END;
                    end
                end
                ST_STOP_END: begin
                    if (tick_end) begin
                        state <= ST_IDLE;          // Busy drops here
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/cfg_sequencer.sv */
`timescale 1ns/100ps
`include "cam_cfg_config.svh"

module cfg_sequencer (
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  logic                   i_start,     // Run request, used in idle or done
    input  cam_cfg_pkg::cfg_word_u i_word,      // ROM data, one clock behind o_addr
    input  logic                   i_sccb_busy, // Bus master cycle in progress
    output logic [`CAM_ROM_AW-1:0] o_addr,
    output cam_cfg_pkg::sccb_req_t o_req,
    output logic                   o_req_stb,   // One clock write strobe
    output logic                   o_busy,
    output logic                   o_done       // Held until next accepted start
);

    localparam int DLY_W = $clog2(`CAM_DELAY_CYCLES + 1);

    // Marker words seen through the union
    localparam cam_cfg_pkg::cfg_word_u MARK_DELAY = `CAM_MARK_DELAY;
    localparam cam_cfg_pkg::cfg_word_u MARK_END   = `CAM_MARK_END;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,       // ROM read in flight
        ST_DECODE,      // Word valid this clock
        ST_ISSUE,       // Strobe to bus master
        ST_WAIT_BUS,    // SCCB cycle running
        ST_DELAY,       // Marker pause
        ST_DONE
    } state_t;

    state_t           state;
    logic [DLY_W-1:0] dly_cnt;     // Delay countdown
    logic             is_mark;     // Upper byte flags a special word
    logic             is_delay;
    logic             is_end;

    assign is_mark  = (i_word.special.marker == MARK_END.special.marker);
    assign is_delay = is_mark && (i_word.special.opcode == MARK_DELAY.special.opcode);
    assign is_end   = is_mark && !is_delay;    // Unknown markers also stop

    assign o_req_stb = (state == ST_ISSUE) && !i_sccb_busy;
    assign o_busy    = (state != ST_IDLE) && (state != ST_DONE);
    assign o_done    = (state == ST_DONE);

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state   <= ST_IDLE;
            o_addr  <= '0;
            dly_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (i_start) begin
                        o_addr <= '0;              // Always from the top
                        state  <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= ST_DECODE;            // Cover ROM read latency
                end
                ST_DECODE: begin
                    if (is_end) begin
                        state <= ST_DONE;
                    end else if (is_delay) begin
                        dly_cnt <= DLY_W'(`CAM_DELAY_CYCLES - 1);
                        state   <= ST_DELAY;
                    end else begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (!i_sccb_busy) begin
                        state <= ST_WAIT_BUS;      // Strobe goes out this clock
                    end
                end
                ST_WAIT_BUS: begin
                    // Master raised busy on the strobe edge
                    if (!i_sccb_busy) begin
                        o_addr <= o_addr + 1'b1;
                        state  <= ST_FETCH;
                    end
                end
                ST_DELAY: begin
                    if (dly_cnt == '0) begin
                        o_addr <= o_addr + 1'b1;
                        state  <= ST_FETCH;
                    end else begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request payload, taken from the write view
    always_ff @(posedge i_clk) begin
        if (state == ST_DECODE) begin
            o_req <= i_word.reg_wr;
        end
    end

endmodule

/* source/cfg_rom.sv */
`timescale 1ns/100ps
`include "cam_cfg_config.svh"

module cfg_rom (
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  logic [`CAM_ROM_AW-1:0] i_addr,
    output cam_cfg_pkg::cfg_word_u o_data   // Valid one clock after i_addr
);

    // RGB444 setup table, register address in the upper byte
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            o_data <= '0;
        end else begin
            case (i_addr)
                0:       o_data <= 16'h1280;           // COM7 soft reset
                1:       o_data <= `CAM_MARK_DELAY;    // Let reset settle
                2:       o_data <= 16'h1101;           // CLKRC prescaler
                3:       o_data <= 16'h1206;           // COM7 VGA RGB
                4:       o_data <= 16'h3a04;           // TSLB byte order
                5:       o_data <= 16'h8c02;           // RGB444 on
                6:       o_data <= 16'h40d0;           // COM15 full range
                7:       o_data <= 16'h0c00;           // COM3
                8:       o_data <= 16'h3e00;           // COM14
                9:       o_data <= 16'h703a;           // Horizontal scale
                10:      o_data <= 16'h7135;           // Vertical scale
                11:      o_data <= 16'h7211;           // Downsample control
                12:      o_data <= 16'h73f0;           // Pixel clock divider
                13:      o_data <= 16'ha202;           // Pixel clock delay
                14:      o_data <= 16'h1713;           // HSTART
                15:      o_data <= 16'h1801;           // HSTOP
                16:      o_data <= 16'h32b6;           // HREF edge offsets
                17:      o_data <= 16'h1902;           // VSTART
                18:      o_data <= 16'h1a7a;           // VSTOP
                19:      o_data <= 16'h030a;           // VREF low bits
                20:      o_data <= 16'h4f80;           // Matrix coef 1
                21:      o_data <= 16'h5080;           // Matrix coef 2
                22:      o_data <= 16'h5100;           // Matrix coef 3
                23:      o_data <= 16'h5222;           // Matrix coef 4
                24:      o_data <= 16'h535e;           // Matrix coef 5
                25:      o_data <= 16'h5480;           // Matrix coef 6
                26:      o_data <= 16'h589e;           // Matrix signs
                27:      o_data <= 16'h0e61;           // COM5
                28:      o_data <= 16'h13e7;           // COM8 AGC AEC AWB
                29:      o_data <= 16'h1e31;           // MVFP mirror, flip
                30:      o_data <= 16'h3dc3;           // COM13 gamma, UV
                31:      o_data <= 16'h1500;           // COM10 sync polarity
                32:      o_data <= `CAM_MARK_END;      // Last entry
                default: o_data <= `CAM_MARK_END;      // Past table stops run
            endcase
        end
    end

endmodule

/* source/cam_cfg_pkg.sv */
package cam_cfg_pkg;

    // One SCCB register write
    typedef struct packed {
        logic [7:0] reg_addr;   // Camera register
        logic [7:0] reg_data;   // Value to write
    } sccb_req_t;

    // Marker view of a ROM word
    typedef struct packed {
        logic [7:0] marker;     // 0xFF for special words
        logic [7:0] opcode;     // Delay or end
    } cfg_special_t;

    // A ROM word is either a register write or a marker
    typedef union packed {
        sccb_req_t    reg_wr;   // Address byte, then value byte
        cfg_special_t special;  // Marker byte, then opcode byte
    } cfg_word_u;

endpackage

/* source/cam_cfg_config.svh */
`ifndef CAM_CFG_CONFIG_SVH
`define CAM_CFG_CONFIG_SVH

// Camera device address, write direction
`define CAM_SCCB_ID         8'h42

// SCCB bit timing in system clocks
`define CAM_SCCB_HALF       125         // Half SIOC period, 200 kHz at 50 MHz

// Wait after a delay marker
`define CAM_DELAY_CYCLES    50000       // 1 ms at 50 MHz, camera reset settle

// Configuration ROM size
`define CAM_ROM_AW          8           // Address bits

// Special ROM words, upper byte 0xFF marks them
`define CAM_MARK_DELAY      16'hFFF0    // Timed pause
`define CAM_MARK_END        16'hFFFF    // Table end

`endif
